/* Bender.yml */
package:
  name: ibuff

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/ibuff_pkg.sv
      - ibuff/ibuff_ram.sv
      - ibuff/ibuff_compact.sv
      - ibuff/ibuff_ctrl.sv
      - rtl/ibuff_top.sv

  - target: test
    include_dirs:
      - common
    files:
      - tb/tb_ibuff_top.sv

/* common/ibuff_params.svh */
`ifndef IBUFF_PARAMS_SVH
`define IBUFF_PARAMS_SVH

// instruction slots offered by fetch each cycle
// also the number of write ports on each payload RAM
`define IBUFF_FETCH_WIDTH 4

// dispatch lanes, one RAM read port per lane
`define IBUFF_DISPATCH_WIDTH 2

// number of buffer entries, must be a power of two
`define IBUFF_DEPTH 16

// bits needed to index one entry
`define IBUFF_INDEX 4

`endif

/* common/ibuff_pkg.sv */
`include "ibuff_params.svh"

package ibuff_pkg;

  // one fetched instruction and the pc it came from
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] instr;
  } inst_t;

  // prediction that fetch attached to the instruction
  // ctrl_type is the branch class from the predecode step
  typedef struct packed {
    logic        pred_taken;
    logic [1:0]  ctrl_type;
    logic [31:0] target;
  } bp_info_t;

  // entry index, wraps at the buffer depth
  typedef logic [`IBUFF_INDEX-1:0] idx_t;

  // occupancy, one extra bit so a full buffer is representable
  typedef logic [`IBUFF_INDEX:0] cnt_t;

  // slots written in one cycle, 0 up to the fetch width
  typedef logic [$clog2(`IBUFF_FETCH_WIDTH+1)-1:0] slot_cnt_t;

  // position of a slot inside a fetch packet
  typedef logic [$clog2(`IBUFF_FETCH_WIDTH)-1:0] slot_idx_t;

endpackage

/* ibuff/ibuff_compact.sv */
`timescale 1ns/10ps

`include "ibuff_params.svh"

module ibuff_compact (
  input  logic                  accept_i,
  input  logic                  fetch_mask_i  [`IBUFF_FETCH_WIDTH],
  input  ibuff_pkg::idx_t       tail_i,

  output logic                  we_o          [`IBUFF_FETCH_WIDTH],
  output ibuff_pkg::idx_t       waddr_o       [`IBUFF_FETCH_WIDTH],
  output ibuff_pkg::slot_idx_t  slot_sel_o    [`IBUFF_FETCH_WIDTH],
  output ibuff_pkg::slot_cnt_t  num_written_o
);

  // rank of each slot among the valid slots before it
  ibuff_pkg::slot_cnt_t rank [`IBUFF_FETCH_WIDTH];
  // number of valid slots in the packet
  ibuff_pkg::slot_cnt_t pop_cnt;

  // exclusive prefix count over the mask
  always_comb
  begin
    ibuff_pkg::slot_cnt_t run;
    run = '0;
    for (int j = 0; j < `IBUFF_FETCH_WIDTH; j++)
    begin
      rank[j] = run;
      if (fetch_mask_i[j])
      begin
        run = run + ibuff_pkg::slot_cnt_t'(1);
      end
    end
    pop_cnt = run;
  end

  // write port r takes the valid slot whose rank is r
  always_comb
  begin
    for (int r = 0; r < `IBUFF_FETCH_WIDTH; r++)
    begin
      slot_sel_o[r] = '0;
      for (int j = 0; j < `IBUFF_FETCH_WIDTH; j++)
      begin
        if (fetch_mask_i[j] && (rank[j] == ibuff_pkg::slot_cnt_t'(r)))
        begin
          slot_sel_o[r] = ibuff_pkg::slot_idx_t'(j);
        end
      end

      // ports beyond the valid count stay idle
      we_o[r]    = accept_i && (ibuff_pkg::slot_cnt_t'(r) < pop_cnt);
      // consecutive entries from the tail, wrapping with the index width
      waddr_o[r] = tail_i + ibuff_pkg::idx_t'(r);
    end
  end

  // nothing lands in the buffer for a refused packet
  assign num_written_o = accept_i ? pop_cnt : '0;

endmodule

/* ibuff/ibuff_ctrl.sv */
`timescale 1ns/10ps

`include "ibuff_params.svh"

module ibuff_ctrl (
  input  logic                  clk,
  input  logic                  rst_n_i,

  input  logic                  fetch_valid_i,
  input  logic                  flush_i,
  input  logic                  backend_stall_i,
  input  ibuff_pkg::slot_cnt_t  num_written_i,

  output logic                  accept_o,
  output logic                  stall_o,
  output ibuff_pkg::idx_t       tail_o,
  output ibuff_pkg::idx_t       raddr_o       [`IBUFF_DISPATCH_WIDTH],
  output logic                  disp_valid_o  [`IBUFF_DISPATCH_WIDTH]
);

  ibuff_pkg::idx_t  head_q;
  ibuff_pkg::idx_t  tail_q;
  ibuff_pkg::cnt_t  count_q;

  ibuff_pkg::cnt_t  free_cnt;
  // lanes currently showing a valid entry
  ibuff_pkg::cnt_t  lane_cnt;
  // lanes taken by dispatch this cycle
  ibuff_pkg::cnt_t  consume_cnt;
  ibuff_pkg::cnt_t  count_next;

  assign free_cnt = ibuff_pkg::cnt_t'(`IBUFF_DEPTH) - count_q;

  // whole packets only, so refuse when a full-width packet might not fit
  // depends on the count alone, never on this cycle's mask
  assign stall_o  = free_cnt < ibuff_pkg::cnt_t'(`IBUFF_FETCH_WIDTH);

  assign accept_o = fetch_valid_i && !stall_o && !flush_i;

  assign lane_cnt = (count_q > ibuff_pkg::cnt_t'(`IBUFF_DISPATCH_WIDTH)) ?
                    ibuff_pkg::cnt_t'(`IBUFF_DISPATCH_WIDTH) : count_q;

  // every valid lane leaves unless the back end holds it
  assign consume_cnt = backend_stall_i ? '0 : lane_cnt;

  assign count_next = count_q + ibuff_pkg::cnt_t'(num_written_i) - consume_cnt;

  // read indices for the oldest entries
  always_comb
  begin
    for (int k = 0; k < `IBUFF_DISPATCH_WIDTH; k++)
    begin
      raddr_o[k]      = head_q + ibuff_pkg::idx_t'(k);
      disp_valid_o[k] = ibuff_pkg::cnt_t'(k) < count_q;
    end
  end

  assign tail_o = tail_q;

  // pointers wrap naturally with the index width
  always_ff @(posedge clk)
  begin
    if (!rst_n_i || flush_i)
    begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end
    else
    begin
      head_q  <= head_q + ibuff_pkg::idx_t'(consume_cnt);
      tail_q  <= tail_q + ibuff_pkg::idx_t'(num_written_i);
      count_q <= count_next;
    end
  end

endmodule

/* ibuff/ibuff_ram.sv */
`timescale 1ns/10ps

`include "ibuff_params.svh"

module ibuff_ram #(
  parameter type T     = ibuff_pkg::inst_t,
  parameter int  DEPTH = `IBUFF_DEPTH,
  parameter int  NWR   = `IBUFF_FETCH_WIDTH,
  parameter int  NRD   = `IBUFF_DISPATCH_WIDTH
) (
  input  logic              clk,

  input  logic              we_i    [NWR],
  input  ibuff_pkg::idx_t   waddr_i [NWR],
  input  T                  wdata_i [NWR],

  input  ibuff_pkg::idx_t   raddr_i [NRD],
  output T                  rdata_o [NRD]
);

  // entry storage, contents only matter where the control says valid
  T mem [DEPTH];

  // asynchronous read ports
  always_comb
  begin
    for (int r = 0; r < NRD; r++)
    begin
      rdata_o[r] = mem[raddr_i[r]];
    end
  end

  // clocked writes
  // enabled ports always carry distinct indices, so order does not matter
  always_ff @(posedge clk)
  begin
    for (int w = 0; w < NWR; w++)
    begin
      if (we_i[w])
      begin
        mem[waddr_i[w]] <= wdata_i[w];
      end
    end
  end

endmodule

/* rtl/ibuff_top.sv */
`timescale 1ns/10ps

`include "ibuff_params.svh"

module ibuff_top (
  input  logic                 clk,
  input  logic                 rst_n_i,

  // fetch side
  input  logic                 fetch_valid_i,
  input  logic                 fetch_mask_i  [`IBUFF_FETCH_WIDTH],
  input  ibuff_pkg::inst_t     fetch_inst_i  [`IBUFF_FETCH_WIDTH],
  input  ibuff_pkg::bp_info_t  fetch_bp_i    [`IBUFF_FETCH_WIDTH],
  output logic                 stall_o,

  // back end control
  input  logic                 backend_stall_i,
  input  logic                 flush_i,

  // dispatch side
  output logic                 disp_valid_o  [`IBUFF_DISPATCH_WIDTH],
  output ibuff_pkg::inst_t     disp_inst_o   [`IBUFF_DISPATCH_WIDTH],
  output ibuff_pkg::bp_info_t  disp_bp_o     [`IBUFF_DISPATCH_WIDTH]
);

  logic                  accept;
  ibuff_pkg::idx_t       tail;
  ibuff_pkg::idx_t       raddr       [`IBUFF_DISPATCH_WIDTH];
  ibuff_pkg::slot_cnt_t  num_written;

  logic                  we          [`IBUFF_FETCH_WIDTH];
  ibuff_pkg::idx_t       waddr       [`IBUFF_FETCH_WIDTH];
  ibuff_pkg::slot_idx_t  slot_sel    [`IBUFF_FETCH_WIDTH];

  ibuff_pkg::inst_t      wr_inst     [`IBUFF_FETCH_WIDTH];
  ibuff_pkg::bp_info_t   wr_bp       [`IBUFF_FETCH_WIDTH];

  ibuff_ctrl u_ctrl (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .fetch_valid_i   (fetch_valid_i),
    .flush_i         (flush_i),
    .backend_stall_i (backend_stall_i),
    .num_written_i   (num_written),
    .accept_o        (accept),
    .stall_o         (stall_o),
    .tail_o          (tail),
    .raddr_o         (raddr),
    .disp_valid_o    (disp_valid_o)
  );

  ibuff_compact u_compact (
    .accept_i      (accept),
    .fetch_mask_i  (fetch_mask_i),
    .tail_i        (tail),
    .we_o          (we),
    .waddr_o       (waddr),
    .slot_sel_o    (slot_sel),
    .num_written_o (num_written)
  );

  // steer the selected fetch slot onto each write port
  always_comb
  begin
    for (int r = 0; r < `IBUFF_FETCH_WIDTH; r++)
    begin
      wr_inst[r] = fetch_inst_i[slot_sel[r]];
      wr_bp[r]   = fetch_bp_i[slot_sel[r]];
    end
  end

  // both payload RAMs share enables and indices
  ibuff_ram #(
    .T     (ibuff_pkg::inst_t),
    .DEPTH (`IBUFF_DEPTH),
    .NWR   (`IBUFF_FETCH_WIDTH),
    .NRD   (`IBUFF_DISPATCH_WIDTH)
  ) u_inst_ram (
    .clk     (clk),
    .we_i    (we),
    .waddr_i (waddr),
    .wdata_i (wr_inst),
    .raddr_i (raddr),
    .rdata_o (disp_inst_o)
  );

  ibuff_ram #(
    .T     (ibuff_pkg::bp_info_t),
    .DEPTH (`IBUFF_DEPTH),
    .NWR   (`IBUFF_FETCH_WIDTH),
    .NRD   (`IBUFF_DISPATCH_WIDTH)
  ) u_bp_ram (
    .clk     (clk),
    .we_i    (we),
    .waddr_i (waddr),
    .wdata_i (wr_bp),
    .raddr_i (raddr),
    .rdata_o (disp_bp_o)
  );

endmodule

/* tb.f */
+incdir+common
common/ibuff_pkg.sv
ibuff/ibuff_ram.sv
ibuff/ibuff_compact.sv
ibuff/ibuff_ctrl.sv
rtl/ibuff_top.sv
tb/tb_ibuff_top.sv

/* tb/tb_ibuff_top.sv */
`timescale 1ns/10ps

`include "ibuff_params.svh"

module tb_ibuff_top;

  localparam int CLK_PERIOD = 8;
  localparam int FW         = `IBUFF_FETCH_WIDTH;
  localparam int DW         = `IBUFF_DISPATCH_WIDTH;
  localparam int DEPTH      = `IBUFF_DEPTH;

  logic                 clk;
  logic                 rst_n_i;
  logic                 fetch_valid;
  logic                 fetch_mask    [FW];
  ibuff_pkg::inst_t     fetch_inst    [FW];
  ibuff_pkg::bp_info_t  fetch_bp      [FW];
  logic                 stall;
  logic                 backend_stall;
  logic                 flush;
  logic                 disp_valid    [DW];
  ibuff_pkg::inst_t     disp_inst     [DW];
  ibuff_pkg::bp_info_t  disp_bp       [DW];

  // stimulus table, one entry per cycle
  string                row_name          [$];
  bit                   row_fetch_valid   [$];
  bit [FW-1:0]          row_mask          [$];
  bit                   row_backend_stall [$];
  bit                   row_flush         [$];
  bit                   table_ready;

  // reference model of the buffer contents, oldest entry at the front
  ibuff_pkg::inst_t     model_inst [$];
  ibuff_pkg::bp_info_t  model_bp   [$];

  // payloads offered in the current row
  ibuff_pkg::inst_t     cur_inst [FW];
  ibuff_pkg::bp_info_t  cur_bp   [FW];

  integer               seed;
  integer               timeout_ns;

  ibuff_top dut (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .fetch_valid_i   (fetch_valid),
    .fetch_mask_i    (fetch_mask),
    .fetch_inst_i    (fetch_inst),
    .fetch_bp_i      (fetch_bp),
    .stall_o         (stall),
    .backend_stall_i (backend_stall),
    .flush_i         (flush),
    .disp_valid_o    (disp_valid),
    .disp_inst_o     (disp_inst),
    .disp_bp_o       (disp_bp)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic stop_on_error();
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act)
    begin
      $display("error %s: expected %0b actual %0b", name, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_inst(input string name, input ibuff_pkg::inst_t exp,
                            input ibuff_pkg::inst_t act);
    if (exp !== act)
    begin
      $display("error %s: expected pc=%08h instr=%08h actual pc=%08h instr=%08h",
               name, exp.pc, exp.instr, act.pc, act.instr);
      stop_on_error();
    end
  endtask

  task automatic check_bp(input string name, input ibuff_pkg::bp_info_t exp,
                          input ibuff_pkg::bp_info_t act);
    if (exp !== act)
    begin
      $display("error %s: expected taken=%0b type=%0d tgt=%08h actual taken=%0b type=%0d tgt=%08h",
               name, exp.pred_taken, exp.ctrl_type, exp.target,
               act.pred_taken, act.ctrl_type, act.target);
      stop_on_error();
    end
  endtask

  task automatic add_row(input string name, input bit fv, input bit [FW-1:0] mask,
                         input bit bs, input bit fl);
    row_name.push_back(name);
    row_fetch_valid.push_back(fv);
    row_mask.push_back(mask);
    row_backend_stall.push_back(bs);
    row_flush.push_back(fl);
  endtask

  task automatic build_table();
    add_row("idle_0",            1'b0, 4'b0000, 1'b0, 1'b0);
    // sparse masks come out packed
    add_row("sparse_13",         1'b1, 4'b1010, 1'b0, 1'b0);
    add_row("sparse_02",         1'b1, 4'b0101, 1'b0, 1'b0);
    add_row("sparse_3",          1'b1, 4'b1000, 1'b0, 1'b0);
    add_row("drain_0",           1'b0, 4'b0000, 1'b0, 1'b0);
    add_row("drain_1",           1'b0, 4'b0000, 1'b0, 1'b0);
    // back end holds while fetch fills the buffer
    add_row("hold_fill_0",       1'b1, 4'b1111, 1'b1, 1'b0);
    add_row("hold_fill_1",       1'b1, 4'b1111, 1'b1, 1'b0);
    add_row("hold_fill_2",       1'b1, 4'b1111, 1'b1, 1'b0);
    add_row("hold_fill_3",       1'b1, 4'b1011, 1'b1, 1'b0);
    add_row("full_refused_0",    1'b1, 4'b1111, 1'b1, 1'b0);
    add_row("full_refused_1",    1'b1, 4'b0001, 1'b1, 1'b0);
    add_row("release_0",         1'b1, 4'b1111, 1'b0, 1'b0);
    add_row("release_1",         1'b1, 4'b1111, 1'b0, 1'b0);
    add_row("release_2",         1'b1, 4'b1111, 1'b0, 1'b0);
    add_row("hold_mid",          1'b1, 4'b0110, 1'b1, 1'b0);
    add_row("release_3",         1'b0, 4'b0000, 1'b0, 1'b0);
    add_row("release_4",         1'b0, 4'b0000, 1'b0, 1'b0);
    // packet offered together with the flush is dropped
    add_row("flush_with_packet", 1'b1, 4'b1111, 1'b0, 1'b1);
    add_row("after_flush",       1'b0, 4'b0000, 1'b0, 1'b0);
    add_row("flush_empty",       1'b1, 4'b0011, 1'b1, 1'b1);
    add_row("after_flush_1",     1'b0, 4'b0000, 1'b0, 1'b0);
    // mixed traffic, pointers pass the end of the array
    add_row("wrap_00",           1'b1, 4'b1111, 1'b0, 1'b0);
    add_row("wrap_01",           1'b1, 4'b0111, 1'b0, 1'b0);
    add_row("wrap_02",           1'b1, 4'b1101, 1'b1, 1'b0);
    add_row("wrap_03",           1'b1, 4'b1111, 1'b0, 1'b0);
    add_row("wrap_04",           1'b0, 4'b1111, 1'b0, 1'b0);
    add_row("wrap_05",           1'b1, 4'b1001, 1'b0, 1'b0);
    add_row("wrap_06",           1'b1, 4'b1111, 1'b1, 1'b0);
    add_row("wrap_07",           1'b1, 4'b1111, 1'b0, 1'b0);
    add_row("wrap_08",           1'b1, 4'b0000, 1'b0, 1'b0);
    add_row("wrap_09",           1'b1, 4'b1110, 1'b0, 1'b0);
    add_row("wrap_10",           1'b1, 4'b0011, 1'b1, 1'b0);
    add_row("wrap_11",           1'b1, 4'b1111, 1'b0, 1'b0);
    add_row("wrap_12",           1'b1, 4'b0100, 1'b0, 1'b0);
    add_row("wrap_13",           1'b0, 4'b0000, 1'b0, 1'b0);
    add_row("wrap_14",           1'b1, 4'b1111, 1'b0, 1'b0);
    add_row("wrap_15",           1'b1, 4'b1011, 1'b0, 1'b0);
    add_row("wrap_16",           1'b0, 4'b0000, 1'b0, 1'b0);
    add_row("wrap_drain_0",      1'b0, 4'b0000, 1'b0, 1'b0);
    add_row("wrap_drain_1",      1'b0, 4'b0000, 1'b0, 1'b0);
    add_row("wrap_drain_2",      1'b0, 4'b0000, 1'b0, 1'b0);
    add_row("wrap_drain_3",      1'b0, 4'b0000, 1'b0, 1'b0);
  endtask

  // fresh random payloads on every slot, masked or not
  task automatic drive_row(input int row);
    logic [31:0] rnd;
    for (int s = 0; s < FW; s++)
    begin
      cur_inst[s].pc    = $random(seed);
      cur_inst[s].instr = $random(seed);
      rnd               = $random(seed);
      cur_bp[s].pred_taken = rnd[2];
      cur_bp[s].ctrl_type  = rnd[1:0];
      cur_bp[s].target     = $random(seed);
    end
    fetch_valid   <= row_fetch_valid[row];
    backend_stall <= row_backend_stall[row];
    flush         <= row_flush[row];
    for (int s = 0; s < FW; s++)
    begin
      fetch_mask[s] <= row_mask[row][s];
      fetch_inst[s] <= cur_inst[s];
      fetch_bp[s]   <= cur_bp[s];
    end
  endtask

  task automatic check_outputs(input string name);
    int   lanes;
    logic exp_stall;
    lanes     = (model_inst.size() < DW) ? model_inst.size() : DW;
    exp_stall = (DEPTH - model_inst.size()) < FW;
    check_bit({name, " stall"}, exp_stall, stall);
    for (int k = 0; k < DW; k++)
    begin
      check_bit($sformatf("%s lane%0d valid", name, k), k < lanes, disp_valid[k]);
      if (k < lanes)
      begin
        check_inst($sformatf("%s lane%0d inst", name, k), model_inst[k], disp_inst[k]);
        check_bp($sformatf("%s lane%0d bp", name, k), model_bp[k], disp_bp[k]);
      end
    end
  endtask

  // what the buffer should hold after the coming edge
  task automatic update_model(input int row);
    int lanes;
    bit accepted;
    lanes    = (model_inst.size() < DW) ? model_inst.size() : DW;
    accepted = row_fetch_valid[row] && ((DEPTH - model_inst.size()) >= FW);
    if (row_flush[row])
    begin
      model_inst.delete();
      model_bp.delete();
    end
    else
    begin
      if (!row_backend_stall[row])
      begin
        for (int k = 0; k < lanes; k++)
        begin
          void'(model_inst.pop_front());
          void'(model_bp.pop_front());
        end
      end
      if (accepted)
      begin
        for (int s = 0; s < FW; s++)
        begin
          if (row_mask[row][s])
          begin
            model_inst.push_back(cur_inst[s]);
            model_bp.push_back(cur_bp[s]);
          end
        end
      end
    end
  endtask

  initial
  begin
    wait (table_ready);
    timeout_ns = (row_name.size() + 10) * CLK_PERIOD;
    #(timeout_ns);
    $display("timeout: run did not finish within %0d ns", timeout_ns);
    $display("Done: errors found");
    $fatal(1);
  end

  initial
  begin
    seed          = 32'hd57b;
    rst_n_i       = 1'b0;
    fetch_valid   = 1'b0;
    backend_stall = 1'b0;
    flush         = 1'b0;
    for (int s = 0; s < FW; s++)
    begin
      fetch_mask[s] = 1'b0;
      fetch_inst[s] = '0;
      fetch_bp[s]   = '0;
    end
    build_table();
    table_ready = 1'b1;

    repeat (3) @(posedge clk);
    rst_n_i <= 1'b1;
    @(negedge clk);
    check_outputs("after_reset");

    for (int i = 0; i < row_name.size(); i++)
    begin
      @(posedge clk);
      drive_row(i);
      @(negedge clk);
      check_outputs(row_name[i]);
      update_model(i);
    end

    // last row is idle, so the model already holds the settled state
    @(posedge clk);
    @(negedge clk);
    check_outputs("end_of_table");

    $display("Done: no errors");
    $finish;
  end

endmodule
